// File: src.f
+incdir+hdl
hdl/octree_pkg.sv
hdl/sram_pkg.sv
hdl/octree_addr_gen.sv
hdl/anchor_walker.sv
hdl/octree_updater.sv
testbench/octree_updater_checker.sv
testbench/tb_octree_updater.sv

// File: Bender.yml
package:
  name: octree_updater

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/octree_pkg.sv
      - hdl/sram_pkg.sv
      - hdl/octree_addr_gen.sv
      - hdl/anchor_walker.sv
      - hdl/octree_updater.sv
  - target: test
    files:
      - testbench/octree_updater_checker.sv
      - testbench/tb_octree_updater.sv

// File: testbench/octree_trace.txt
# op pos writes last_addr last_data, one command per line
# op: A add, D delete, X add with a delete strobe during the walk
# pos, last_addr and last_data in hex, writes in decimal
# level-3 node into an empty tree, one write per level
A 355e 4 066 0000000004000010
# sibling in the same group, only its self bit
A 3559 1 073 0000000020080000
D 3559 1 073 0000000020000000
# level-2 node, the delete strobe must be dropped
X 29c0 3 08c 0000000040000100
# level-0 node alone in its group
A 0c00 1 0b2 0000000000002000
D 0c00 1 0b2 0000000000000000
# remove the rest, each walk clears up to the root
D 29c0 3 08c 0000000000000000
D 355e 4 066 0000000000000000

// File: testbench/tb_octree_updater.sv
`timescale 1ns/1ps
`default_nettype none

module tb_octree_updater;

  localparam int unsigned TREE_START   = 64;
  localparam int unsigned MEM_WORDS    = 1024;
  localparam int unsigned DONE_TIMEOUT = 64;

  logic                 clk;
  logic                 rst_n;
  logic                 add_anchor;
  logic                 del_anchor;
  octree_pkg::pos_t     pos_encode;
  logic                 add_done;
  logic                 del_done;
  logic                 sram_cen;
  logic                 sram_gwen;
  sram_pkg::sram_addr_t sram_a;
  sram_pkg::sram_data_t sram_d;
  sram_pkg::sram_data_t sram_q;

  // sram model and write bookkeeping
  sram_pkg::sram_data_t mem [MEM_WORDS];
  bit                   touched [MEM_WORDS];
  int unsigned          write_count    = 0;
  int unsigned          add_done_count = 0;
  int unsigned          del_done_count = 0;
  sram_pkg::sram_addr_t last_addr;
  sram_pkg::sram_data_t last_data;

  int unsigned          value_errors  = 0;
  int unsigned          other_errors  = 0;
  int unsigned          assert_errors = 0;
  logic                 timed_out     = 1'b0;

  octree_updater #(
    .TREE_START (TREE_START)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .add_anchor (add_anchor),
    .del_anchor (del_anchor),
    .pos_encode (pos_encode),
    .add_done   (add_done),
    .del_done   (del_done),
    .sram_cen   (sram_cen),
    .sram_gwen  (sram_gwen),
    .sram_a     (sram_a),
    .sram_d     (sram_d),
    .sram_q     (sram_q)
  );

  bind octree_updater octree_updater_checker checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .sram_cen   (sram_cen),
    .sram_gwen  (sram_gwen),
    .add_done   (add_done),
    .del_done   (del_done),
    .walk_state (walker_i.state)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  //////////////////////////////////////////////////
  // sram model, one cycle read latency
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!sram_cen) begin
      if (!sram_gwen) begin
        mem[sram_a] <= sram_d;
      end else begin
        sram_q <= mem[sram_a];
      end
    end
  end

  // mid-cycle, every DUT output is settled
  always @(negedge clk) begin
    if (rst_n && !sram_cen && !sram_gwen) begin
      write_count++;
      last_addr       = sram_a;
      last_data       = sram_d;
      touched[sram_a] = 1'b1;
    end
    if (add_done) begin
      add_done_count++;
    end
    if (del_done) begin
      del_done_count++;
    end
  end

  task automatic expect_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("Fail %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic check_idle_outputs();
    expect_value("sram_cen while idle", sram_cen, 1'b1);
    expect_value("sram_gwen while idle", sram_gwen, 1'b1);
    expect_value("add_done while idle", add_done, 1'b0);
    expect_value("del_done while idle", del_done, 1'b0);
  endtask

  task automatic wait_for_done();
    int unsigned cycles;
    logic        seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && !timed_out) begin
      @(negedge clk);
      if (add_done || del_done) begin
        seen = 1'b1;
      end else if (cycles == DONE_TIMEOUT) begin
        timed_out = 1'b1;
        other_errors++;
        $display("no done pulse within %0d cycles, gave up at %0t", DONE_TIMEOUT, $time);
      end
      cycles++;
    end
  endtask

  task automatic run_command(input byte op, input octree_pkg::pos_t pos,
                             input int unsigned exp_writes,
                             input sram_pkg::sram_addr_t exp_addr,
                             input sram_pkg::sram_data_t exp_data);
    int unsigned writes_before;
    int unsigned adds_before;
    int unsigned dels_before;
    int unsigned gap;
    logic        is_add;
    writes_before = write_count;
    adds_before   = add_done_count;
    dels_before   = del_done_count;
    is_add        = (op != "D");
    pos_encode    = pos;
    add_anchor    = is_add;
    del_anchor    = !is_add;
    @(negedge clk);
    add_anchor = 1'b0;
    del_anchor = 1'b0;
    if (op == "X") begin
      // competing delete, other position, mid-walk
      @(negedge clk);
      del_anchor = 1'b1;
      pos_encode = ~pos;
      @(negedge clk);
      del_anchor = 1'b0;
    end
    wait_for_done();
    if (!timed_out) begin
      // idle gap also catches stray pulses
      gap = 2 + ($urandom % 4);
      repeat (gap) @(negedge clk);
      expect_value($sformatf("writes for pos 0x%0h", pos),
                   write_count - writes_before, exp_writes);
      if (exp_writes > 0) begin
        expect_value("last write address", last_addr, exp_addr);
        expect_value("last write data", last_data, exp_data);
      end
      expect_value("add_done pulses", add_done_count - adds_before, is_add);
      expect_value("del_done pulses", del_done_count - dels_before, !is_add);
      check_idle_outputs();
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int                   fd;
    string                line;
    byte                  op;
    octree_pkg::pos_t     pos;
    int unsigned          nwr;
    sram_pkg::sram_addr_t addr;
    sram_pkg::sram_data_t data;
    int                   fields;
    int unsigned          cmd_count;
    int unsigned          touched_count;
    void'($urandom(95));
    cmd_count     = 0;
    touched_count = 0;
    rst_n      = 1'b0;
    add_anchor = 1'b0;
    del_anchor = 1'b0;
    pos_encode = '0;
    sram_q     = '0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]     = '0;
      touched[a] = 1'b0;
    end

    repeat (4) begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_idle_outputs();
    end

    fd = $fopen("testbench/octree_trace.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open testbench/octree_trace.txt");
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%c %h %d %h %h", op, pos, nwr, addr, data);
          if (fields == 5) begin
            run_command(op, pos, nwr, addr, data);
            cmd_count++;
          end else begin
            other_errors++;
            $display("trace line could not be parsed: %s", line);
          end
        end
      end
      $fclose(fd);
    end

    assert (cmd_count > 0) else begin
      other_errors++;
      $display("the trace held no commands");
    end

    // every word the walks wrote must be clear again
    if (!timed_out) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        if (touched[a]) begin
          touched_count++;
          expect_value($sformatf("final word at 0x%0h", a), mem[a], '0);
        end
      end
      assert (touched_count > 0) else begin
        other_errors++;
        $display("no SRAM writes were seen during the run");
      end
    end

    assert_errors = dut_i.checker_i.assert_fails;
    $display("errors: %0d value, %0d assertion, %0d other",
             value_errors, assert_errors, other_errors);
    if (value_errors == 0 && assert_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/octree_updater_checker.sv
`timescale 1ns/1ps
`default_nettype none

module octree_updater_checker (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    sram_cen,
  input logic                    sram_gwen,
  input logic                    add_done,
  input logic                    del_done,
  input octree_pkg::walk_state_e walk_state
);

  // failed assertions so far, read back by the testbench
  int unsigned assert_fails = 0;

  // a write is always also an access
  gwen_needs_cen: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_gwen |-> !sram_cen)
    else begin
      $error("sram_gwen low while sram_cen is high");
      assert_fails++;
    end

  dones_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(add_done && del_done))
    else begin
      $error("add_done and del_done high in the same cycle");
      assert_fails++;
    end

  //////////////////////////////////////////////////
  // done pulses last one cycle
  //////////////////////////////////////////////////

  add_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    add_done |=> !add_done)
    else begin
      $error("add_done held high for more than one cycle");
      assert_fails++;
    end

  del_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    del_done |=> !del_done)
    else begin
      $error("del_done held high for more than one cycle");
      assert_fails++;
    end

  // no sram traffic without a walk
  idle_no_access: assert property (@(posedge clk) disable iff (!rst_n)
    (walk_state == octree_pkg::WALK_IDLE) |-> sram_cen)
    else begin
      $error("sram_cen low while the walker is idle");
      assert_fails++;
    end

endmodule

`default_nettype wire

// File: hdl/octree_updater.sv
`timescale 1ns/1ps
`default_nettype none

module octree_updater #(
  parameter int unsigned TREE_START = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 add_anchor,
  input  logic                 del_anchor,
  input  octree_pkg::pos_t     pos_encode,
  output logic                 add_done,
  output logic                 del_done,
  output logic                 sram_cen,
  output logic                 sram_gwen,
  output sram_pkg::sram_addr_t sram_a,
  output sram_pkg::sram_data_t sram_d,
  input  sram_pkg::sram_data_t sram_q
);

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_ADDING,
    CMD_DELETING
  } cmd_state_e;

  cmd_state_e cmd_state;
  logic       accept;
  logic       walk_start;
  logic       walk_set;
  logic       walk_finish;

  //////////////////////////////////////////////////
  // command acceptance
  //////////////////////////////////////////////////

  // strobes outside idle are dropped, add wins a tie
  assign accept     = (cmd_state == CMD_IDLE) && (add_anchor || del_anchor);
  assign walk_start = accept;
  assign walk_set   = add_anchor;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_state <= CMD_IDLE;
    end else begin
      case (cmd_state)
        CMD_IDLE: begin
          if (add_anchor) begin
            cmd_state <= CMD_ADDING;
          end else if (del_anchor) begin
            cmd_state <= CMD_DELETING;
          end
        end
        CMD_ADDING, CMD_DELETING: begin
          if (walk_finish) begin
            cmd_state <= CMD_IDLE;
          end
        end
        default: begin
          cmd_state <= CMD_IDLE;
        end
      endcase
    end
  end

  // finish goes back to whichever command started the walk
  assign add_done = walk_finish && (cmd_state == CMD_ADDING);
  assign del_done = walk_finish && (cmd_state == CMD_DELETING);

  anchor_walker #(
    .TREE_START (TREE_START)
  ) walker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (walk_start),
    .set_mode  (walk_set),
    .pos       (pos_encode),
    .finish    (walk_finish),
    .sram_cen  (sram_cen),
    .sram_gwen (sram_gwen),
    .sram_a    (sram_a),
    .sram_d    (sram_d),
    .sram_q    (sram_q)
  );

endmodule

`default_nettype wire

// File: hdl/anchor_walker.sv
`timescale 1ns/1ps
`default_nettype none

`include "octree_macros.svh"

module anchor_walker #(
  parameter int unsigned TREE_START = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 set_mode,
  input  octree_pkg::pos_t     pos,
  output logic                 finish,
  output logic                 sram_cen,
  output logic                 sram_gwen,
  output sram_pkg::sram_addr_t sram_a,
  output sram_pkg::sram_data_t sram_d,
  input  sram_pkg::sram_data_t sram_q
);

  octree_pkg::walk_state_e            state;

  // held position, level field drops by one per step
  octree_pkg::pos_t                   walk_pos;
  octree_pkg::level_t                 walk_level;
  logic                               mode_set;
  // self bit on the node itself, child bit on every ancestor
  logic                               first_level;

  sram_pkg::sram_data_t               rd_word;
  sram_pkg::sram_addr_t               word_addr;
  sram_pkg::lane_t                    lane;
  octree_pkg::offset_t                slot;

  logic [$clog2(`OCT_GROUP_W)-1:0]    flag_idx;
  logic [$clog2(`SRAM_DATA_W)-1:0]    bit_idx;
  logic [`OCT_GROUP_W-1:0]            group_bits;
  logic [`OCT_GROUP_W-1:0]            flag_mask;
  sram_pkg::sram_data_t               word_mask;
  logic                               others_empty;

  assign walk_level = walk_pos[`OCT_POS_W-1 -: `OCT_LEVEL_W];

  octree_addr_gen #(
    .TREE_START (TREE_START)
  ) addr_gen_i (
    .pos       (walk_pos),
    .word_addr (word_addr),
    .lane      (lane),
    .slot      (slot)
  );

  //////////////////////////////////////////////////
  // flag bit selection
  //////////////////////////////////////////////////

  // bit 2k is the child flag, 2k+1 the self flag
  assign flag_idx = {slot, first_level};
  assign bit_idx  = {lane, flag_idx};

  always_comb begin
    flag_mask           = '0;
    flag_mask[flag_idx] = 1'b1;
  end

  always_comb begin
    word_mask          = '0;
    word_mask[bit_idx] = 1'b1;
  end

  assign group_bits = rd_word[lane*`OCT_GROUP_W +: `OCT_GROUP_W];

  // same test for both modes
  // add: group was empty before the set
  // delete: group is empty after the clear
  assign others_empty = ((group_bits & ~flag_mask) == '0);

  //////////////////////////////////////////////////
  // sram port
  //////////////////////////////////////////////////

  assign sram_cen  = !((state == octree_pkg::WALK_READ) ||
                       (state == octree_pkg::WALK_WRITE));
  assign sram_gwen = (state != octree_pkg::WALK_WRITE);
  assign sram_a    = word_addr;
  assign sram_d    = mode_set ? (rd_word | word_mask) : (rd_word & ~word_mask);

  assign finish = (state == octree_pkg::WALK_FINISH);

  // read data lands during the wait cycle
  always_ff @(posedge clk) begin
    if (state == octree_pkg::WALK_WAIT) begin
      rd_word <= sram_q;
    end
  end

  //////////////////////////////////////////////////
  // walk FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= octree_pkg::WALK_IDLE;
      walk_pos    <= '0;
      mode_set    <= 1'b0;
      first_level <= 1'b0;
    end else begin
      case (state)
        octree_pkg::WALK_IDLE: begin
          if (start) begin
            walk_pos    <= pos;
            mode_set    <= set_mode;
            first_level <= 1'b1;
            state       <= octree_pkg::WALK_READ;
          end
        end
        octree_pkg::WALK_READ: begin
          state <= octree_pkg::WALK_WAIT;
        end
        octree_pkg::WALK_WAIT: begin
          state <= octree_pkg::WALK_WRITE;
        end
        octree_pkg::WALK_WRITE: begin
          // climb only while the group has nothing else in it
          if (others_empty && (walk_level != '0)) begin
            walk_pos[`OCT_POS_W-1 -: `OCT_LEVEL_W] <=
              octree_pkg::level_t'(walk_level - 1'b1);
            first_level <= 1'b0;
            state       <= octree_pkg::WALK_READ;
          end else begin
            state <= octree_pkg::WALK_FINISH;
          end
        end
        octree_pkg::WALK_FINISH: begin
          state <= octree_pkg::WALK_IDLE;
        end
        default: begin
          state <= octree_pkg::WALK_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/octree_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "octree_macros.svh"

module octree_addr_gen #(
  parameter int unsigned TREE_START = 0
) (
  input  octree_pkg::pos_t     pos,
  output sram_pkg::sram_addr_t word_addr,
  output sram_pkg::lane_t      lane,
  output octree_pkg::offset_t  slot
);

  // group index reaches 73 at level 3
  localparam int unsigned GROUP_IDX_W = 7;

  octree_pkg::level_t          level;
  octree_pkg::offset_t         offs [`OCT_TREE_LEVEL];
  logic [GROUP_IDX_W-1:0]      group_idx;

  //////////////////////////////////////////////////
  // field split
  //////////////////////////////////////////////////

  always_comb begin
    level = pos[`OCT_POS_W-1 -: `OCT_LEVEL_W];
    for (int i = 0; i < `OCT_TREE_LEVEL; i++) begin
      offs[i] = pos[`OCT_POS_W-`OCT_LEVEL_W-1-i*`OCT_OFFSET_W -: `OCT_OFFSET_W];
    end
  end

  //////////////////////////////////////////////////
  // group index within one subtree
  //////////////////////////////////////////////////

  // o0 picks the subtree, so it never enters the group index
  always_comb begin
    case (level)
      2'd0: group_idx = '0;
      2'd1: group_idx = GROUP_IDX_W'(1);
      2'd2: begin
        group_idx = GROUP_IDX_W'(`OCT_GROUP_BASE_L2) + GROUP_IDX_W'(offs[1]);
      end
      default: begin
        group_idx = GROUP_IDX_W'(`OCT_GROUP_BASE_L3)
                  + GROUP_IDX_W'({offs[1], 3'b000})
                  + GROUP_IDX_W'(offs[2]);
      end
    endcase
  end

  // four groups per word, low two bits select the lane
  assign word_addr = sram_pkg::sram_addr_t'(TREE_START)
                   + sram_pkg::sram_addr_t'(`OCT_WORDS_PER_TREE)
                     * sram_pkg::sram_addr_t'(offs[0])
                   + sram_pkg::sram_addr_t'(group_idx[GROUP_IDX_W-1:2]);

  assign lane = group_idx[1:0];

  // node's own slot in its group
  assign slot = offs[level];

endmodule

`default_nettype wire

// File: hdl/sram_pkg.sv
`default_nettype none

`include "octree_macros.svh"

package sram_pkg;

  // flag groups packed into one sram word
  localparam int unsigned LANES = `SRAM_DATA_W / `OCT_GROUP_W;

  typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;
  typedef logic [`SRAM_DATA_W-1:0] sram_data_t;

  // which 16-bit group inside the word
  typedef logic [$clog2(LANES)-1:0] lane_t;

endpackage

`default_nettype wire

// File: hdl/octree_pkg.sv
`default_nettype none

`include "octree_macros.svh"

package octree_pkg;

  //////////////////////////////////////////////////
  // position encoding
  //////////////////////////////////////////////////

  // {level, o0, o1, o2, o3}, o0 sits just below the level field
  typedef logic [`OCT_POS_W-1:0]    pos_t;
  typedef logic [`OCT_LEVEL_W-1:0]  level_t;

  // child index inside the parent, also the slot in a flag group
  typedef logic [`OCT_OFFSET_W-1:0] offset_t;

  //////////////////////////////////////////////////
  // walker FSM
  //////////////////////////////////////////////////

  // one pass of read, wait, write per visited level
  typedef enum logic [2:0] {
    WALK_IDLE,
    WALK_READ,
    WALK_WAIT,
    WALK_WRITE,
    WALK_FINISH
  } walk_state_e;

endpackage

`default_nettype wire

// File: hdl/octree_macros.svh
`ifndef OCTREE_MACROS_SVH
`define OCTREE_MACROS_SVH

// tree geometry
`define OCT_TREE_LEVEL      4
`define OCT_LEVEL_W         2
`define OCT_OFFSET_W        3
// level field plus one offset per level
`define OCT_POS_W           14

// flag groups per subtree: 1 + 1 + 8 + 64 = 74, four to a word
`define OCT_WORDS_PER_TREE  19
`define OCT_GROUP_BASE_L2   2
`define OCT_GROUP_BASE_L3   10

// local sram
`define SRAM_ADDR_W         10
`define SRAM_DATA_W         64
// two flag bits for each of eight children
`define OCT_GROUP_W         16

`endif
